//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbLocalRepairBp
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- bpCommitUpdate.sv
`timescale 1ns/1ps

module bpCommitUpdate import bpPkg::*; (
  // execute
  input  logic                branchE,
  input  logic                pcSrcE,
  input  logic [ctrBits-1:0]  dirPredE,
  // memory
  input  logic [ctrBits-1:0]  dirPredM,
  input  logic                pcSrcM,
  // writeback
  input  logic                branchW,
  input  logic                stallW,
  input  logic                flushW,
  input  logic                pcSrcW,
  input  logic [histBits-1:0] lhrW,
  input  logic [xLen-1:0]     pcW,
  // to the core and the pattern table
  output logic                dirPredWrongE,
  output logic [ctrBits-1:0]  newDirPredM,
  // committed history write
  output logic                commitWrEn,
  output logic [idxBits-1:0]  commitIdx,
  output logic [histBits-1:0] commitHist
);

  ////////////////////////////////////////////////////////////////////////////
  // execute, misprediction check
  ////////////////////////////////////////////////////////////////////////////

  // only a real branch can be wrong, non-branches keep the flag low
  assign dirPredWrongE = branchE & (pcSrcE != dirPredE[ctrTakenBit]);

  ////////////////////////////////////////////////////////////////////////////
  // memory, counter update
  ////////////////////////////////////////////////////////////////////////////

  // step toward the outcome, stick at both ends
  always_comb begin
    case (dirPredM)
      ctrStrongNot: begin
        newDirPredM = pcSrcM ? ctrWeakNot : ctrStrongNot;
      end
      ctrWeakNot: begin
        newDirPredM = pcSrcM ? ctrWeakTaken : ctrStrongNot;
      end
      ctrWeakTaken: begin
        newDirPredM = pcSrcM ? ctrStrongTaken : ctrWeakNot;
      end
      // strong taken, the only encoding left
      default: begin
        newDirPredM = pcSrcM ? ctrStrongTaken : ctrWeakTaken;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // writeback, committed history
  ////////////////////////////////////////////////////////////////////////////

  // same condition as the pattern table write
  assign commitWrEn = branchW & ~stallW & ~flushW;

  // index from the branch's own pc
  assign commitIdx = bpIndex(pcW);

  // real outcome enters at the top, oldest bit drops off
  assign commitHist = {pcSrcW, lhrW[histBits-1:1]};

endmodule

//--- bpHistSelect.sv
`timescale 1ns/1ps

module bpHistSelect import bpPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stallF,
  input  logic                flushD,
  input  logic [xLen-1:0]     pcNextF,
  // speculative history write from decode
  input  logic                specWrEn,
  input  logic [idxBits-1:0]  specIdx,
  input  logic [histBits-1:0] specHist,
  // committed history write from writeback
  input  logic                commitWrEn,
  input  logic [idxBits-1:0]  commitIdx,
  input  logic [histBits-1:0] commitHist,
  // history chosen for the fetch instruction
  output logic [histBits-1:0] lhrF
);

  // read index for both history tables
  logic [idxBits-1:0]  rdIdxNextF;
  // the two candidate histories, valid in fetch
  logic [histBits-1:0] lhrCommitF;
  logic [histBits-1:0] lhrSpecF;
  // one bit per index, set means the speculative entry is stale
  logic [bhtDepth-1:0] flushedBits;
  // flushed bit of the fetch index, sampled with the tables
  logic                specFlushedF;

  assign rdIdxNextF = bpIndex(pcNextF);

  ////////////////////////////////////////////////////////////////////////////
  // history tables
  ////////////////////////////////////////////////////////////////////////////

  // committed local history, updated at writeback
  bpRam2p #(
    .depth(bhtDepth),
    .width(histBits)
  ) bht (
    .clk    (clk),
    .rdEn   (~stallF),
    .rdAddr (rdIdxNextF),
    .rdData (lhrCommitF),
    .wrEn   (commitWrEn),
    .wrAddr (commitIdx),
    .wrData (commitHist)
  );

  // speculative history buffer, updated from decode
  // same read index and timing as the committed table
  bpRam2p #(
    .depth(bhtDepth),
    .width(histBits)
  ) shb (
    .clk    (clk),
    .rdEn   (~stallF),
    .rdAddr (rdIdxNextF),
    .rdData (lhrSpecF),
    .wrEn   (specWrEn),
    .wrAddr (specIdx),
    .wrData (specHist)
  );

  ////////////////////////////////////////////////////////////////////////////
  // flushed-bit array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      // nothing speculative yet, trust the committed copy
      flushedBits  <= '1;
      specFlushedF <= 1'b1;
    end else begin
      // sample on the edge that reads the tables
      if (!stallF) begin
        specFlushedF <= flushedBits[rdIdxNextF];
      end
      // a decode flush drops every speculative entry
      if (flushD) begin
        flushedBits <= '1;
      end
      // a fresh speculative write wins over a flush on the same edge
      if (specWrEn) begin
        flushedBits[specIdx] <= 1'b0;
      end
    end
  end

  // speculative copy only while its flushed bit is clear
  assign lhrF = specFlushedF ? lhrCommitF : lhrSpecF;

endmodule

//--- bpPkg.sv
package bpPkg;

  ////////////////////////////////////////////////////////////////////////////
  // predictor sizes
  ////////////////////////////////////////////////////////////////////////////

  // pc width, one word
  localparam int xLen = 32;
  // local history table index width
  localparam int idxBits = 6;
  // local history length per branch
  localparam int histBits = 10;
  // one history register per index
  localparam int bhtDepth = 2 ** idxBits;
  // one counter per history pattern
  localparam int phtDepth = 2 ** histBits;

  ////////////////////////////////////////////////////////////////////////////
  // 2-bit saturating counters
  ////////////////////////////////////////////////////////////////////////////

  localparam int ctrBits = 2;
  // upper counter bit is the taken prediction
  localparam int ctrTakenBit = ctrBits - 1;

  localparam logic [ctrBits-1:0] ctrStrongNot   = 2'b00;
  localparam logic [ctrBits-1:0] ctrWeakNot     = 2'b01;
  localparam logic [ctrBits-1:0] ctrWeakTaken   = 2'b10;
  localparam logic [ctrBits-1:0] ctrStrongTaken = 2'b11;

  // history table index from a pc
  // word bits give the low part, bit 1 is folded into the top bit
  // so compressed branches spread over both table halves
  function automatic logic [idxBits-1:0] bpIndex(input logic [xLen-1:0] pc);
    return {pc[idxBits+1] ^ pc[1], pc[idxBits:2]};
  endfunction

endpackage

//--- bpPredictPipe.sv
`timescale 1ns/1ps

module bpPredictPipe import bpPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  // core pipeline control
  input  logic                stallD,
  input  logic                stallE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushD,
  input  logic                flushE,
  input  logic                flushM,
  input  logic                flushW,
  input  logic                branchD,
  input  logic                branchM,
  input  logic                pcSrcE,
  input  logic [xLen-1:0]     pcD,
  input  logic [xLen-1:0]     pcM,
  // history chosen in fetch
  input  logic [histBits-1:0] lhrF,
  // updated counter from memory
  input  logic [ctrBits-1:0]  newDirPredM,
  // prediction down the pipe
  output logic [ctrBits-1:0]  dirPredD,
  output logic [ctrBits-1:0]  dirPredE,
  output logic [ctrBits-1:0]  dirPredM,
  output logic                pcSrcM,
  output logic                pcSrcW,
  output logic [histBits-1:0] lhrW,
  output logic [xLen-1:0]     pcW,
  output logic                branchW,
  // speculative history write
  output logic                specWrEn,
  output logic [idxBits-1:0]  specIdx,
  output logic [histBits-1:0] specHist
);

  logic [histBits-1:0] lhrD;
  logic [histBits-1:0] lhrE;
  logic [histBits-1:0] lhrM;
  logic [ctrBits-1:0]  newDirPredW;
  logic                phtWrEn;

  ////////////////////////////////////////////////////////////////////////////
  // pattern history table
  ////////////////////////////////////////////////////////////////////////////

  // counter is written only by a live branch leaving writeback
  assign phtWrEn = branchW & ~stallW & ~flushW;

  // read at the edge into decode, so dirPredD lines up with lhrD
  bpRam2p #(
    .depth(phtDepth),
    .width(ctrBits)
  ) pht (
    .clk    (clk),
    .rdEn   (~stallD),
    .rdAddr (lhrF),
    .rdData (dirPredD),
    .wrEn   (phtWrEn),
    .wrAddr (lhrW),
    .wrData (newDirPredW)
  );

  // decode branch pushes its predicted direction into the speculative copy
  // only when it actually moves on to execute
  assign specWrEn = branchD & ~stallE & ~flushE;
  assign specIdx  = bpIndex(pcD);
  assign specHist = {dirPredD[ctrTakenBit], lhrD[histBits-1:1]};

  ////////////////////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////////////////////

  // each stage holds on stall, clears on flush while enabled
  always_ff @(posedge clk) begin
    if (!rstN) begin
      lhrD <= '0;
    end else if (!stallD) begin
      lhrD <= flushD ? '0 : lhrF;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dirPredE <= '0;
      lhrE     <= '0;
    end else if (!stallE) begin
      dirPredE <= flushE ? '0 : dirPredD;
      lhrE     <= flushE ? '0 : lhrD;
    end
  end

  // outcome joins the prediction here
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dirPredM <= '0;
      lhrM     <= '0;
      pcSrcM   <= 1'b0;
    end else if (!stallM) begin
      dirPredM <= flushM ? '0 : dirPredE;
      lhrM     <= flushM ? '0 : lhrE;
      pcSrcM   <= flushM ? 1'b0 : pcSrcE;
    end
  end

  // everything the table writes need at the end of writeback
  always_ff @(posedge clk) begin
    if (!rstN) begin
      newDirPredW <= '0;
      lhrW        <= '0;
      pcSrcW      <= 1'b0;
      branchW     <= 1'b0;
      pcW         <= '0;
    end else if (!stallW) begin
      newDirPredW <= flushW ? '0 : newDirPredM;
      lhrW        <= flushW ? '0 : lhrM;
      pcSrcW      <= flushW ? 1'b0 : pcSrcM;
      branchW     <= flushW ? 1'b0 : branchM;
      pcW         <= flushW ? '0 : pcM;
    end
  end

endmodule

//--- bpRam2p.sv
`timescale 1ns/1ps

module bpRam2p #(
  parameter int depth = 64,
  parameter int width = 10
) (
  input  logic                     clk,
  // read port
  input  logic                     rdEn,
  input  logic [$clog2(depth)-1:0] rdAddr,
  output logic [width-1:0]         rdData,
  // write port
  input  logic                     wrEn,
  input  logic [$clog2(depth)-1:0] wrAddr,
  input  logic [width-1:0]         wrData
);

  logic [width-1:0] mem [depth];

  // tables start cleared
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // write port
  always @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // registered read that holds its value while rdEn is low
  // a read of the address being written returns the old entry
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

//--- compile.f
bpPkg.sv
bpRam2p.sv
bpHistSelect.sv
bpPredictPipe.sv
bpCommitUpdate.sv
localRepairBp.sv
tbClock.sv
tbLocalRepairBp.sv

//--- localRepairBp.sv
`timescale 1ns/1ps

module localRepairBp import bpPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  // stage holds
  input  logic               stallF,
  input  logic               stallD,
  input  logic               stallE,
  input  logic               stallM,
  input  logic               stallW,
  // stage kills
  input  logic               flushD,
  input  logic               flushE,
  input  logic               flushM,
  input  logic               flushW,
  // branch in stage
  input  logic               branchD,
  input  logic               branchE,
  input  logic               branchM,
  // resolved direction in execute
  input  logic               pcSrcE,
  input  logic [xLen-1:0]    pcNextF,
  input  logic [xLen-1:0]    pcD,
  input  logic [xLen-1:0]    pcM,
  // prediction for the decode instruction
  output logic [ctrBits-1:0] dirPredD,
  output logic               dirPredWrongE
);

  // fetch history
  logic [histBits-1:0] lhrF;
  // speculative write, decode side
  logic                specWrEn;
  logic [idxBits-1:0]  specIdx;
  logic [histBits-1:0] specHist;
  // pipelined prediction and outcome
  logic [ctrBits-1:0]  dirPredE;
  logic [ctrBits-1:0]  dirPredM;
  logic [ctrBits-1:0]  newDirPredM;
  logic                pcSrcM;
  logic                pcSrcW;
  logic [histBits-1:0] lhrW;
  logic [xLen-1:0]     pcW;
  logic                branchW;
  // committed write, writeback side
  logic                commitWrEn;
  logic [idxBits-1:0]  commitIdx;
  logic [histBits-1:0] commitHist;

  // lookup and history choice in fetch
  bpHistSelect histSelect_i (.clk, .rstN, .stallF, .flushD, .pcNextF,
                             .specWrEn, .specIdx, .specHist,
                             .commitWrEn, .commitIdx, .commitHist, .lhrF);

  // pattern table and D to W registers
  bpPredictPipe predictPipe_i (.clk, .rstN,
                               .stallD, .stallE, .stallM, .stallW,
                               .flushD, .flushE, .flushM, .flushW,
                               .branchD, .branchM, .pcSrcE, .pcD, .pcM,
                               .lhrF, .newDirPredM,
                               .dirPredD, .dirPredE, .dirPredM,
                               .pcSrcM, .pcSrcW, .lhrW, .pcW, .branchW,
                               .specWrEn, .specIdx, .specHist);

  // mispredict flag, counter update, committed history
  bpCommitUpdate commitUpdate_i (.branchE, .pcSrcE, .dirPredE,
                                 .dirPredM, .pcSrcM,
                                 .branchW, .stallW, .flushW, .pcSrcW,
                                 .lhrW, .pcW,
                                 .dirPredWrongE, .newDirPredM,
                                 .commitWrEn, .commitIdx, .commitHist);

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rstN
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held low for five rising edges, released just after the fifth
  initial begin
    rstN = 1'b0;
    repeat (5) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

//--- tbLocalRepairBp.sv
`timescale 1ns/1ps

module tbLocalRepairBp;

  logic clk, rstN;
  logic stallF, stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushM, flushW;
  logic branchD, branchE, branchM, pcSrcE;
  logic [31:0] pcNextF, pcD, pcM;
  logic [1:0] dirPredD;
  logic dirPredWrongE;

  // core-side instruction stages that the DUT does not see
  logic [31:0] pcF, pcE;
  logic brF, tkF, tkD, brNF, tkNF;
  string testName;
  logic [31:0] hotPc [4];

  // reference state of tables and stages
  logic [9:0] mBht [64];
  logic [9:0] mShb [64];
  logic [1:0] mPht [1024];
  logic [63:0] mFlushed;
  logic mSpecFlushedF;
  logic [9:0] mLhrCommitF, mLhrSpecF, mLhrD, mLhrE, mLhrM, mLhrW;
  logic [1:0] mDirPredD, mDirPredE, mDirPredM, mNewW;
  logic mPcSrcM, mPcSrcW, mBranchW;
  logic [31:0] mPcW;

  tbClock clock_i (.clk(clk), .rstN(rstN));

  localRepairBp localRepairBp_i (.*);

  // top index bit is pc[7] xor pc[1], low bits are pc[6:2]
  function automatic logic [5:0] hashPc(input logic [31:0] pc);
    return {pc[7] ^ pc[1], pc[6:2]};
  endfunction

  // saturating 2-bit counter step toward the outcome
  function automatic logic [1:0] nextCounter(input logic [1:0] ctr, input logic taken);
    if (taken) begin
      return (ctr == 2'b11) ? 2'b11 : ctr + 2'b01;
    end
    return (ctr == 2'b00) ? 2'b00 : ctr - 2'b01;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++) begin
      mBht[i] = '0;
      mShb[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      mPht[i] = '0;
    end
    mLhrCommitF = '0;
    mLhrSpecF = '0;
    mDirPredD = '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // one rising edge of tables, flushed bits and stage registers
  function automatic void stepModel();
    logic [9:0] lhrF, rdCommit, rdSpec;
    logic [1:0] rdPht, newM;
    logic [5:0] fIdx;
    logic specWr, commitWr;
    lhrF = mSpecFlushedF ? mLhrCommitF : mLhrSpecF;
    newM = nextCounter(mDirPredM, mPcSrcM);
    fIdx = hashPc(pcNextF);
    specWr = branchD & ~stallE & ~flushE;
    commitWr = mBranchW & ~stallW & ~flushW;
    // reads see the old table contents
    rdCommit = mBht[fIdx];
    rdSpec = mShb[fIdx];
    rdPht = mPht[lhrF];
    if (specWr) begin
      mShb[hashPc(pcD)] = {mDirPredD[1], mLhrD[9:1]};
    end
    if (commitWr) begin
      mBht[hashPc(mPcW)] = {mPcSrcW, mLhrW[9:1]};
      mPht[mLhrW] = mNewW;
    end
    if (!stallF) begin
      mLhrCommitF = rdCommit;
      mLhrSpecF = rdSpec;
    end
    if (!rstN) begin
      mFlushed = '1;
      mSpecFlushedF = 1'b1;
      {mNewW, mLhrW, mPcSrcW, mBranchW, mPcW} = '0;
      {mDirPredM, mLhrM, mPcSrcM} = '0;
      {mDirPredE, mLhrE} = '0;
      mLhrD = '0;
    end else begin
      if (!stallF) mSpecFlushedF = mFlushed[fIdx];
      if (flushD) mFlushed = '1;
      if (specWr) mFlushed[hashPc(pcD)] = 1'b0;
      // later stages first so each takes the old value of the one before
      if (!stallW) {mNewW, mLhrW, mPcSrcW, mBranchW, mPcW} =
          flushW ? '0 : {newM, mLhrM, mPcSrcM, branchM, pcM};
      if (!stallM) {mDirPredM, mLhrM, mPcSrcM} = flushM ? '0 : {mDirPredE, mLhrE, pcSrcE};
      if (!stallE) {mDirPredE, mLhrE} = flushE ? '0 : {mDirPredD, mLhrD};
      if (!stallD) mLhrD = flushD ? '0 : lhrF;
    end
    if (!stallD) mDirPredD = rdPht;
  endfunction

  always @(posedge clk) begin
    stepModel();
  end

  // compare where outputs are settled
  always @(negedge clk) begin
    logic expWrong;
    if (rstN) begin
      expWrong = branchE & (pcSrcE != mDirPredE[1]);
      assert (dirPredD == mDirPredD) else begin
        $display("[FAIL] %s dirPredD expected %0h actual %0h", testName, mDirPredD, dirPredD);
        $display("TEST FAILED");
        $fatal(1, "prediction mismatch");
      end
      assert (dirPredWrongE == expWrong) else begin
        $display("[FAIL] %s dirPredWrongE expected %0h actual %0h",
                 testName, expWrong, dirPredWrongE);
        $display("TEST FAILED");
        $fatal(1, "misprediction flag mismatch");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // mode 0 hot pc always taken, 1 hot pc random outcome
  // 2 random hot pcs and branches, 3 no branches
  task automatic stepCycle(input int mode, input int stallPct, input int flushPct);
    int depth;
    int flushAt;
    @(posedge clk);
    #1;
    // advance the instruction stages with last cycle's levels
    if (!stallM) {pcM, branchM} = flushM ? '0 : {pcE, branchE};
    if (!stallE) {pcE, branchE, pcSrcE} = flushE ? '0 : {pcD, branchD, tkD};
    if (!stallD) {pcD, branchD, tkD} = flushD ? '0 : {pcF, brF, tkF};
    if (!stallF) begin
      {pcF, brF, tkF} = {pcNextF, brNF, tkNF};
      pcNextF = (mode == 2 || mode == 3) ? hotPc[$urandom % 4] : hotPc[0];
      brNF = (mode < 2) || (mode == 2 && ($urandom % 2) == 1);
      tkNF = (mode == 0) || ($urandom % 2) == 1;
    end
    // stalls freeze a prefix of the pipe, front end first
    depth = (($urandom % 100) < stallPct) ? 1 + ($urandom % 5) : 0;
    {stallF, stallD, stallE, stallM, stallW} =
        {depth >= 1, depth >= 2, depth >= 3, depth >= 4, depth >= 5};
    flushAt = (($urandom % 100) < flushPct) ? 1 + ($urandom % 4) : 0;
    {flushD, flushE, flushM, flushW} =
        {flushAt == 1, flushAt == 2, flushAt == 3, flushAt == 4};
  endtask

  task automatic runPhase(input string name, input int cycles, input int mode,
                          input int stallPct, input int flushPct);
    testName = name;
    for (int i = 0; i < cycles; i++) begin
      stepCycle(mode, stallPct, flushPct);
    end
  endtask

  initial begin
    int waitCount;
    void'($urandom(32'h2118_cc56));
    hotPc = '{32'h0000_0100, 32'h0000_0144, 32'h0000_2108, 32'h0000_03fc};
    testName = "reset";
    {stallF, stallD, stallE, stallM, stallW} = '0;
    {flushD, flushE, flushM, flushW} = '0;
    {branchD, branchE, branchM, pcSrcE} = '0;
    {pcNextF, pcD, pcM, pcF, pcE} = '0;
    {brF, tkF, tkD, brNF, tkNF} = '0;
    waitCount = 0;
    while (!rstN) begin
      @(posedge clk);
      waitCount++;
      if (waitCount > 20) begin
        $display("TEST FAILED");
        $fatal(1, "reset was never released");
      end
    end
    runPhase("afterReset", 40, 3, 0, 0);
    runPhase("training", 120, 0, 0, 0);
    runPhase("specRepair", 150, 1, 0, 0);
    runPhase("flushRecovery", 200, 2, 0, 25);
    runPhase("stalls", 300, 2, 40, 0);
    runPhase("mixedRandom", 4000, 2, 25, 10);
    // let the last branches leave the pipe
    testName = "drain";
    waitCount = 0;
    while (branchD || branchE || branchM || mBranchW || brF) begin
      stepCycle(3, 0, 0);
      waitCount++;
      if (waitCount > 50) begin
        $display("TEST FAILED");
        $fatal(1, "pipeline did not drain");
      end
    end
    $display("TEST PASSED");
    $finish;
  end

  // hard limit on run time
  initial begin
    #200000;
    $display("TEST FAILED");
    $fatal(1, "simulation ran past its time limit");
  end

endmodule
